//--- common/robPkg.sv
package robPkg;

    // datapath widths
    localparam int DataWidth    = 32;  // result data and pc
    localparam int RegAddrWidth = 5;

    // what the entry does at retirement
    typedef enum logic [1:0] {
        kindAlu    = 2'd0,
        kindStore  = 2'd1,
        kindBranch = 2'd2
    } opKindT;

    // decoded instruction from the front end
    typedef struct packed {
        logic [RegAddrWidth-1:0] destReg;
        opKindT                  kind;
        logic                    predTaken;
    } issueReqT;

    // execution result, tag travels beside it
    typedef struct packed {
        logic [DataWidth-1:0] data;
        logic                 actualTaken;
        logic [DataWidth-1:0] target;  // branch target
    } completionT;

    typedef struct packed {
        logic [RegAddrWidth-1:0] destReg;
        opKindT                  kind;
        logic                    predTaken;
        logic                    done;  // result has arrived
        logic [DataWidth-1:0]    data;
        logic                    actualTaken;
        logic [DataWidth-1:0]    target;
    } robEntryT;

    // architectural register update at retirement
    typedef struct packed {
        logic [RegAddrWidth-1:0] destReg;
        logic [DataWidth-1:0]    data;
    } regWriteT;

endpackage

//--- dispatch/dispatchUnit.sv
`timescale 1ns/1ps

module dispatchUnit #(
    parameter int TagWidth = 4
) (
    input  logic                clk,
    input  logic                rst,

    // front end
    input  logic                issueEn,
    input  robPkg::issueReqT    issueReq,

    // buffer status and commit side
    input  logic                full,
    input  logic                flush,

    // allocation into the buffer
    output logic                allocEn,
    output logic [TagWidth-1:0] allocTag,
    output robPkg::robEntryT    allocEntry
);

    logic [TagWidth-1:0] tailPtr;  // next free tag

    // refused issues are simply dropped
    assign allocEn  = issueEn && !full && !flush;
    assign allocTag = tailPtr;

    // fresh entry, result fields filled later by completion
    always_comb begin
        allocEntry.destReg     = issueReq.destReg;
        allocEntry.kind        = issueReq.kind;
        allocEntry.predTaken   = issueReq.predTaken;
        allocEntry.done        = 1'b0;
        allocEntry.data        = '0;
        allocEntry.actualTaken = 1'b0;
        allocEntry.target      = '0;
    end

    // tail wraps naturally at RobDepth
    always_ff @(posedge clk) begin
        if (rst) begin
            tailPtr <= '0;
        end else if (flush) begin
            tailPtr <= '0;  // buffer empties, restart at tag 0
        end else if (allocEn) begin
            tailPtr <= tailPtr + TagWidth'(1);
        end
    end

endmodule

//--- rob/reorderBuffer.sv
`timescale 1ns/1ps

module reorderBuffer #(
    parameter int TagWidth = 4,
    parameter int RobDepth = 16
) (
    input  logic                clk,
    input  logic                rst,

    // allocation from dispatch
    input  logic                allocEn,
    input  logic [TagWidth-1:0] allocTag,
    input  robPkg::robEntryT    allocEntry,

    // out-of-order results
    input  logic                completeEn,
    input  logic [TagWidth-1:0] completeTag,
    input  robPkg::completionT  completion,

    // commit side
    input  logic                retire,
    input  logic                flush,

    output logic                full,
    output logic                headReady,
    output logic [TagWidth-1:0] headTag,
    output robPkg::robEntryT    headEntry
);

    localparam int CountWidth = TagWidth + 1;

    robPkg::robEntryT        entries [RobDepth];
    logic [RobDepth-1:0]     occupied;
    logic [TagWidth-1:0]     headPtr;
    logic [CountWidth-1:0]   count;  // entries in flight
    logic                    completeHit;

    // results for free slots are ignored
    assign completeHit = completeEn && occupied[completeTag] && !flush;

    assign full      = (count == CountWidth'(RobDepth));
    assign headTag   = headPtr;
    assign headEntry = entries[headPtr];

    // stores retire without waiting for a result
    assign headReady = occupied[headPtr]
                       && (entries[headPtr].done
                           || entries[headPtr].kind == robPkg::kindStore);

    // entry storage
    always_ff @(posedge clk) begin
        if (allocEn) begin
            entries[allocTag] <= allocEntry;
        end
        if (completeHit) begin
            entries[completeTag].data        <= completion.data;
            entries[completeTag].actualTaken <= completion.actualTaken;
            entries[completeTag].target      <= completion.target;
            entries[completeTag].done        <= 1'b1;
        end
    end

    // occupancy and head pointer
    always_ff @(posedge clk) begin
        if (rst) begin
            occupied <= '0;
            headPtr  <= '0;
        end else if (flush) begin
            // everything younger than the branch is discarded
            occupied <= '0;
            headPtr  <= '0;
        end else begin
            if (allocEn) begin
                occupied[allocTag] <= 1'b1;
            end
            if (retire) begin
                occupied[headPtr] <= 1'b0;
                headPtr           <= headPtr + TagWidth'(1);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            count <= '0;
        end else if (flush) begin
            count <= '0;
        end else if (allocEn && !retire) begin
            count <= count + CountWidth'(1);
        end else if (retire && !allocEn) begin
            count <= count - CountWidth'(1);
        end
    end

endmodule

//--- commit/commitUnit.sv
`timescale 1ns/1ps

module commitUnit #(
    parameter int TagWidth = 4
) (
    input  logic                                clk,
    input  logic                                rst,

    // head of the buffer
    input  logic                                headReady,
    input  logic [TagWidth-1:0]                 headTag,
    input  robPkg::robEntryT                    headEntry,

    output logic                                retire,

    // registered retire outputs
    output logic                                regWriteEn,
    output robPkg::regWriteT                    regWrite,
    output logic                                storeCommitEn,
    output logic [TagWidth-1:0]                 storeCommitTag,
    output logic                                flush,
    output logic [robPkg::DataWidth-1:0]        redirectPc
);

    logic isAlu;
    logic isStore;
    logic mispredict;

    // nothing retires while the flush is out
    assign retire = headReady && !flush;

    assign isAlu      = (headEntry.kind == robPkg::kindAlu);
    assign isStore    = (headEntry.kind == robPkg::kindStore);
    assign mispredict = (headEntry.kind == robPkg::kindBranch)
                        && (headEntry.predTaken != headEntry.actualTaken);

    // one-cycle strobes for the retired entry
    always_ff @(posedge clk) begin
        if (rst) begin
            regWriteEn    <= 1'b0;
            storeCommitEn <= 1'b0;
            flush         <= 1'b0;
        end else begin
            regWriteEn    <= retire && isAlu;
            storeCommitEn <= retire && isStore;
            flush         <= retire && mispredict;
        end
    end

    always_ff @(posedge clk) begin
        if (retire) begin
            regWrite.destReg <= headEntry.destReg;
            regWrite.data    <= headEntry.data;
            storeCommitTag   <= headTag;
            redirectPc       <= headEntry.target;  // used only with flush
        end
    end

endmodule

//--- hdl/robCore.sv
`timescale 1ns/1ps

module robCore #(
    parameter int TagWidth = 4
) (
    input  logic                            clk,
    input  logic                            rst,

    // issue side
    input  logic                            issueEn,
    input  robPkg::issueReqT                issueReq,
    output logic                            allocEn,
    output logic [TagWidth-1:0]             allocTag,
    output logic                            full,

    // completion side
    input  logic                            completeEn,
    input  logic [TagWidth-1:0]             completeTag,
    input  robPkg::completionT              completion,

    // retire side
    output logic                            regWriteEn,
    output robPkg::regWriteT                regWrite,
    output logic                            storeCommitEn,
    output logic [TagWidth-1:0]             storeCommitTag,
    output logic                            flush,
    output logic [robPkg::DataWidth-1:0]    redirectPc
);

    localparam int RobDepth = 1 << TagWidth;

    robPkg::robEntryT    allocEntry;
    robPkg::robEntryT    headEntry;
    logic                headReady;
    logic [TagWidth-1:0] headTag;
    logic                retire;

    dispatchUnit #(
        .TagWidth (TagWidth)
    ) dispatch (
        .clk        (clk),
        .rst        (rst),
        .issueEn    (issueEn),
        .issueReq   (issueReq),
        .full       (full),
        .flush      (flush),
        .allocEn    (allocEn),
        .allocTag   (allocTag),
        .allocEntry (allocEntry)
    );

    reorderBuffer #(
        .TagWidth (TagWidth),
        .RobDepth (RobDepth)
    ) rob (
        .clk         (clk),
        .rst         (rst),
        .allocEn     (allocEn),
        .allocTag    (allocTag),
        .allocEntry  (allocEntry),
        .completeEn  (completeEn),
        .completeTag (completeTag),
        .completion  (completion),
        .retire      (retire),
        .flush       (flush),
        .full        (full),
        .headReady   (headReady),
        .headTag     (headTag),
        .headEntry   (headEntry)
    );

    commitUnit #(
        .TagWidth (TagWidth)
    ) commit (
        .clk            (clk),
        .rst            (rst),
        .headReady      (headReady),
        .headTag        (headTag),
        .headEntry      (headEntry),
        .retire         (retire),
        .regWriteEn     (regWriteEn),
        .regWrite       (regWrite),
        .storeCommitEn  (storeCommitEn),
        .storeCommitTag (storeCommitTag),
        .flush          (flush),
        .redirectPc     (redirectPc)
    );

endmodule

//--- dv/robCore_assertions.sv
`timescale 1ns/1ps

module robCoreAssertions (
    input logic clk,
    input logic rst,
    input logic regWriteEn,
    input logic storeCommitEn,
    input logic flush,
    input logic allocEn,
    input logic full
);

    // one kind of retire output per cycle
    retireStrobesExclusive: assert property (@(posedge clk) disable iff (rst)
        $onehot0({regWriteEn, storeCommitEn, flush}))
        else $error("regWriteEn, storeCommitEn and flush high together");

    noAllocWhenBlocked: assert property (@(posedge clk) disable iff (rst)
        !(allocEn && (full || flush)))
        else $error("allocation while the buffer is full or flushing");

    flushSingleCycle: assert property (@(posedge clk) disable iff (rst)
        flush |=> !flush)  // pulse only
        else $error("flush held for two cycles");

endmodule

bind robCore robCoreAssertions protocolChecks (
    .clk           (clk),
    .rst           (rst),
    .regWriteEn    (regWriteEn),
    .storeCommitEn (storeCommitEn),
    .flush         (flush),
    .allocEn       (allocEn),
    .full          (full)
);

//--- dv/robCoreTb.sv
`timescale 1ns/1ps

module robCoreTb;

    localparam int TagWidth     = 4;
    localparam int RobDepth     = 1 << TagWidth;
    localparam int NumRandomOps = 600;
    localparam int NumOps       = NumRandomOps + 4 * RobDepth;
    localparam int CycleLimit   = NumOps * (RobDepth + 8);

    // retire outcome of one entry
    localparam logic [2:0] actNone   = 3'd0;  // still waiting for its result
    localparam logic [2:0] actWrite  = 3'd1;
    localparam logic [2:0] actStore  = 3'd2;
    localparam logic [2:0] actFlush  = 3'd3;
    localparam logic [2:0] actSilent = 3'd4;  // correctly predicted branch

    typedef struct packed {
        logic [TagWidth-1:0]             tag;
        robPkg::opKindT                  kind;
        logic [robPkg::RegAddrWidth-1:0] destReg;
        logic                            predTaken;
        logic                            done;
        logic                            retired;  // no longer held in the buffer
        logic [robPkg::DataWidth-1:0]    data;
        logic                            actualTaken;
        logic [robPkg::DataWidth-1:0]    target;
    } modelEntryT;

    typedef struct packed {
        logic [2:0]                      action;
        logic [robPkg::RegAddrWidth-1:0] destReg;
        logic [robPkg::DataWidth-1:0]    data;
        logic [TagWidth-1:0]             tag;
        logic [robPkg::DataWidth-1:0]    pc;
    } expectT;

    logic                         clk;
    logic                         rst;
    logic                         issueEn;
    robPkg::issueReqT             issueReq;
    logic                         allocEn;
    logic [TagWidth-1:0]          allocTag;
    logic                         full;
    logic                         completeEn;
    logic [TagWidth-1:0]          completeTag;
    robPkg::completionT           completion;
    logic                         regWriteEn;
    robPkg::regWriteT             regWrite;
    logic                         storeCommitEn;
    logic [TagWidth-1:0]          storeCommitTag;
    logic                         flush;
    logic [robPkg::DataWidth-1:0] redirectPc;

    modelEntryT          model[$];  // program order from the oldest
    logic [TagWidth-1:0] expTail    = '0;
    logic                flushDue   = 1'b0;
    logic [31:0]         rngState   = 32'd49550;
    int                  cycleCount = 0;
    int                  numWrites  = 0;
    int                  numStores  = 0;
    int                  numFlushes = 0;
    int                  numSilent  = 0;

    robCore #(.TagWidth(TagWidth)) dut (.*);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    task automatic abortRun(input string reason);
        $display("%s", reason);
        $display("TESTS FAILED");
        $fatal(1, "run stopped");
    endtask

    task automatic checkValue(input string name, input logic [63:0] actual,
                              input logic [63:0] want);
        if (actual !== want) begin
            abortRun($sformatf("Fail at %0t: %s is 0x%0h, expected 0x%0h",
                               $time, name, actual, want));
        end
    endtask

    function automatic logic [31:0] randomWord();
        logic [31:0] x;
        x = rngState;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        rngState = x;
        return x;
    endfunction

    // expected retire behavior of a model entry
    function automatic expectT retireResult(input modelEntryT e);
        expectT r;
        r         = '0;
        r.destReg = e.destReg;
        r.data    = e.data;
        r.tag     = e.tag;
        r.pc      = e.target;
        case (e.kind)
            robPkg::kindAlu:   r.action = e.done ? actWrite : actNone;
            robPkg::kindStore: r.action = actStore;  // needs no result
            default: begin
                if (!e.done) begin
                    r.action = actNone;
                end else if (e.predTaken != e.actualTaken) begin
                    r.action = actFlush;
                end else begin
                    r.action = actSilent;
                end
            end
        endcase
        return r;
    endfunction

    function automatic logic onlySilentLeft();
        expectT r;
        for (int i = 0; i < model.size(); i++) begin
            r = retireResult(model[i]);
            if (r.action != actSilent) begin
                return 1'b0;
            end
        end
        return 1'b1;
    endfunction

    // index of an outstanding alu or branch entry or -1
    function automatic int pickCompletion(input logic oldestOnly);
        int cand[$];
        for (int i = 0; i < model.size(); i++) begin
            if (!model[i].done && model[i].kind != robPkg::kindStore) begin
                cand.push_back(i);
            end
        end
        if (cand.size() == 0) begin
            return -1;
        end
        if (oldestOnly) begin
            return cand[0];
        end
        return cand[randomWord() % cand.size()];
    endfunction

    task automatic driveIssue(input robPkg::opKindT kind,
                              input logic [robPkg::RegAddrWidth-1:0] dest,
                              input logic pred);
        issueEn            = 1'b1;
        issueReq.kind      = kind;
        issueReq.destReg   = dest;
        issueReq.predTaken = pred;
    endtask

    task automatic driveCompletion(input int idx);
        logic [31:0] r;
        r                      = randomWord();
        completeEn             = 1'b1;
        completeTag            = model[idx].tag;
        completion.data        = randomWord();
        completion.target      = randomWord();
        // about one branch in eight mispredicts
        completion.actualTaken = model[idx].predTaken ^ (r[2:0] == 3'd0);
    endtask

    task automatic drainBuffer();
        int idx;
        while (!onlySilentLeft()) begin
            @(negedge clk);
            issueEn    = 1'b0;
            completeEn = 1'b0;
            idx        = pickCompletion(1'b0);
            if (idx >= 0) begin
                driveCompletion(idx);
            end
        end
        @(negedge clk);
        issueEn    = 1'b0;
        completeEn = 1'b0;
        repeat (RobDepth + 2) @(negedge clk);  // let silent branches leave
    endtask

    // checks retire outputs and tracks issues and completions
    always @(posedge clk) begin : compareResults
        expectT     want;
        modelEntryT entry;
        logic [2:0] seen;
        logic       applied;
        logic       flushing;
        int         inFlight;
        int         headIdx;
        if (!rst) begin
            checkValue("flush", 64'(flush), 64'(flushDue));
            flushing = flushDue;
            flushDue = 1'b0;

            seen = actNone;
            if (regWriteEn) begin
                seen = actWrite;
            end else if (storeCommitEn) begin
                seen = actStore;
            end else if (flush) begin
                seen = actFlush;
            end
            if (seen != actNone) begin
                want = '0;
                while (model.size() > 0) begin
                    want = retireResult(model[0]);
                    if (want.action != actSilent) begin
                        break;
                    end
                    void'(model.pop_front());  // retired without output
                    numSilent++;
                end
                if (model.size() == 0) begin
                    abortRun("a retire output appeared with no instruction outstanding");
                end
                checkValue("retire kind", 64'(seen), 64'(want.action));
                case (seen)
                    actWrite: begin
                        checkValue("regWrite.destReg", 64'(regWrite.destReg),
                                   64'(want.destReg));
                        checkValue("regWrite.data", 64'(regWrite.data), 64'(want.data));
                        numWrites++;
                    end
                    actStore: begin
                        checkValue("storeCommitTag", 64'(storeCommitTag), 64'(want.tag));
                        numStores++;
                    end
                    default: begin
                        checkValue("redirectPc", 64'(redirectPc), 64'(want.pc));
                        numFlushes++;
                    end
                endcase
                void'(model.pop_front());
                if (seen == actFlush) begin
                    model.delete();  // younger entries never commit
                    expTail = '0;
                end
            end

            // oldest held entry leaves once it is ready
            inFlight = 0;
            headIdx  = -1;
            for (int i = 0; i < model.size(); i++) begin
                if (!model[i].retired) begin
                    inFlight++;
                    if (headIdx < 0) begin
                        headIdx = i;
                    end
                end
            end
            if (!flushing) begin
                checkValue("full", 64'(full), 64'(inFlight == RobDepth));
                if (headIdx >= 0) begin
                    want = retireResult(model[headIdx]);
                    if (want.action != actNone) begin
                        entry          = model[headIdx];
                        entry.retired  = 1'b1;
                        model[headIdx] = entry;
                        flushDue       = (want.action == actFlush);
                    end
                end
            end

            if (completeEn) begin
                applied = 1'b0;
                for (int i = 0; i < model.size(); i++) begin
                    if (!applied && !model[i].done && !model[i].retired
                        && model[i].tag == completeTag) begin
                        entry             = model[i];
                        entry.done        = 1'b1;
                        entry.data        = completion.data;
                        entry.actualTaken = completion.actualTaken;
                        entry.target      = completion.target;
                        model[i]          = entry;
                        applied           = 1'b1;
                    end
                end
            end

            checkValue("allocEn", 64'(allocEn),
                       64'(issueEn && !flushing && inFlight < RobDepth));
            if (allocEn) begin
                checkValue("allocTag", 64'(allocTag), 64'(expTail));
                entry           = '0;
                entry.tag       = allocTag;
                entry.kind      = issueReq.kind;
                entry.destReg   = issueReq.destReg;
                entry.predTaken = issueReq.predTaken;
                model.push_back(entry);
                expTail = expTail + TagWidth'(1);
            end
        end
    end

    always @(posedge clk) begin
        cycleCount = cycleCount + 1;
        if (cycleCount > CycleLimit) begin
            abortRun($sformatf("run exceeded the limit of %0d cycles", CycleLimit));
        end
    end

    initial begin
        logic [31:0]    r;
        robPkg::opKindT kind;
        int             idx;
        rst         = 1'b1;
        issueEn     = 1'b0;
        issueReq    = '0;
        completeEn  = 1'b0;
        completeTag = '0;
        completion  = '0;
        repeat (10) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        // quiet until the first issue
        repeat (4) begin
            @(negedge clk);
            checkValue("full", 64'(full), 64'd0);
            checkValue("regWriteEn", 64'(regWriteEn), 64'd0);
            checkValue("storeCommitEn", 64'(storeCommitEn), 64'd0);
            checkValue("flush", 64'(flush), 64'd0);
            checkValue("allocEn", 64'(allocEn), 64'd0);
        end

        for (int n = 0; n < NumRandomOps; n++) begin
            @(negedge clk);
            issueEn    = 1'b0;
            completeEn = 1'b0;
            r          = randomWord();
            if (r[1:0] != 2'b00 && !full) begin
                if (r[4:2] < 3'd4) begin
                    kind = robPkg::kindAlu;
                end else if (r[4:2] < 3'd6) begin
                    kind = robPkg::kindStore;
                end else begin
                    kind = robPkg::kindBranch;
                end
                driveIssue(kind, r[9:5], r[10]);
            end
            if (r[12:11] != 2'b00) begin
                idx = pickCompletion(1'b0);
                if (idx >= 0) begin
                    driveCompletion(idx);
                end
            end
        end
        drainBuffer();

        // fill the buffer with no retirement
        for (int n = 0; n < RobDepth; n++) begin
            @(negedge clk);
            r = randomWord();
            driveIssue(robPkg::kindAlu, r[9:5], 1'b0);
        end
        @(negedge clk);
        checkValue("full", 64'(full), 64'd1);
        driveIssue(robPkg::kindAlu, 5'd31, 1'b0);  // must be refused
        @(negedge clk);
        issueEn = 1'b0;
        checkValue("full", 64'(full), 64'd1);
        driveCompletion(pickCompletion(1'b1));
        @(negedge clk);
        completeEn = 1'b0;
        while (regWriteEn !== 1'b1) begin
            @(negedge clk);
        end
        checkValue("full", 64'(full), 64'd0);
        drainBuffer();

        if (numWrites == 0 || numStores == 0 || numFlushes == 0 || numSilent == 0) begin
            abortRun("some kind of retirement was never exercised");
        end else begin
            $display("TESTS PASSED");
            $finish;
        end
    end

endmodule

//--- robCore.f
common/robPkg.sv
dispatch/dispatchUnit.sv
rob/reorderBuffer.sv
commit/commitUnit.sv
hdl/robCore.sv
dv/robCore_assertions.sv
dv/robCoreTb.sv

//--- run.sh
#!/bin/sh
# Verilator build and run of the robCore testbench

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 --top-module robCoreTb \
    -f robCore.f -o robCoreSim > build.log 2>&1
if [ $? -ne 0 ]; then
    echo "build failed, see build.log"
    exit 1
fi

./obj_dir/robCoreSim > sim.log 2>&1
if [ $? -ne 0 ]; then
    echo "simulation exited with an error status"
fi

if grep -qx "TESTS PASSED" sim.log; then
    echo "PASS"
    exit 0
fi
echo "FAIL, see sim.log"
exit 1
